// ==== Bender.yml ====
package:
  name: zx_memory_map

sources:
  - files:
      - hdl/zx_paging_pkg.sv
      - hdl/zx_master_conf.sv
      - hdl/zx_paging_regs.sv
      - hdl/zx_addr_mapper.sv
      - hdl/zx_read_mux.sv
      - hdl/zx_memory_map.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_zx_memory_map.sv

// ==== hdl/zx_addr_mapper.sv ====
`timescale 1ns/10ps

module zx_addr_mapper #(
   parameter int ROM_BASE_PAGE = 8  // first of four ROM pages
) (
   input  logic        clk,
   input  logic        mrst_n,
   input  logic [15:0] a,
   input  logic [7:0]  din,
   input  logic        mreq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic        boot_mode,
   input  logic [zx_paging_pkg::PAGE_W-1:0] master_page,
   input  logic [1:0]  rom_bank,
   input  logic [2:0]  ram_bank,
   input  logic        allram_mode,
   input  zx_paging_pkg::allram_cfg_t allram_cfg,
   output logic [zx_paging_pkg::SRAM_AW-1:0] sram_addr,
   output logic [7:0]  sram_wdata,
   output logic        sram_we_n,
   output logic        sram_oe_n,
   output logic        bootrom_cs,
   output logic        access_to_screen,
   output logic        mem_rd_q         // registered SRAM read in flight
);

   localparam int PW = zx_paging_pkg::PAGE_W;
   localparam logic [PW-1:0] ROM_PAGE = PW'(ROM_BASE_PAGE);

   zx_paging_pkg::mem_slot_t slot;
   logic [PW-1:0] page;
   logic          rom_slot;
   logic          in_bootrom;    // boot ROM takes the slot, SRAM idle
   logic          wr_block;      // normal-mode ROM is read only
   logic          we_n_d;
   logic          oe_n_d;
   logic          cs_d;
   logic          scr_d;

   assign slot     = zx_paging_pkg::mem_slot_t'(a[15:14]);
   assign rom_slot = (slot == zx_paging_pkg::SLOT_ROM);

   // --------------------------------------------------
   // page selection
   // --------------------------------------------------
   always_comb begin
      page = 7'd0;
      case (slot)
         zx_paging_pkg::SLOT_ROM: begin
            if (!allram_mode)
               page = ROM_PAGE + PW'(rom_bank);
            else if (allram_cfg == zx_paging_pkg::CFG_0123)
               page = 7'd0;
            else
               page = 7'd4;                  // all three other layouts
         end
         zx_paging_pkg::SLOT_4000: begin
            page = 7'd5;                     // screen bank by default
            if (!boot_mode && allram_mode) begin
               case (allram_cfg)
                  zx_paging_pkg::CFG_0123: page = 7'd1;
                  zx_paging_pkg::CFG_4763: page = 7'd7;
                  default:                 page = 7'd5;
               endcase
            end
         end
         zx_paging_pkg::SLOT_8000: begin
            page = 7'd2;
            if (!boot_mode && allram_mode && allram_cfg != zx_paging_pkg::CFG_0123)
               page = 7'd6;
         end
         zx_paging_pkg::SLOT_C000: begin
            if (boot_mode)
               page = master_page;           // firmware picks any page
            else if (!allram_mode)
               page = {4'b0000, ram_bank};
            else if (allram_cfg == zx_paging_pkg::CFG_4567)
               page = 7'd7;
            else
               page = 7'd3;
         end
         default: page = 7'd0;
      endcase
   end

   // --------------------------------------------------
   // strobes and contention, next-state
   // --------------------------------------------------
   assign in_bootrom = boot_mode && rom_slot;
   assign wr_block   = rom_slot && !allram_mode;

   assign cs_d   = !mreq_n && in_bootrom;
   assign oe_n_d = mreq_n || rd_n || in_bootrom;
   assign we_n_d = mreq_n || wr_n || in_bootrom || wr_block;
   assign scr_d  = !boot_mode && !allram_mode && !mreq_n &&
                   (slot == zx_paging_pkg::SLOT_4000 ||
                    (slot == zx_paging_pkg::SLOT_C000 && ram_bank[0]));  // odd banks contend

   // one-cycle pipeline stage
   always_ff @(posedge clk) begin
      sram_addr  <= {page, a[zx_paging_pkg::OFFSET_W-1:0]};  // payload, no reset
      sram_wdata <= din;
      if (!mrst_n) begin
         sram_we_n        <= 1'b1;
         sram_oe_n        <= 1'b1;
         bootrom_cs       <= 1'b0;
         access_to_screen <= 1'b0;
      end else begin
         sram_we_n        <= we_n_d;
         sram_oe_n        <= oe_n_d;
         bootrom_cs       <= cs_d;
         access_to_screen <= scr_d;
      end
   end

   assign mem_rd_q = ~sram_oe_n;

   a_no_we_on_bootrom : assert property (@(posedge clk) disable iff (!mrst_n)
      !(!sram_we_n && bootrom_cs));

   // a CPU write to paged ROM is dropped one cycle later
   a_rom_write_blocked : assert property (@(posedge clk) disable iff (!mrst_n)
      (!mreq_n && !wr_n && rom_slot && !boot_mode && !allram_mode) |=> sram_we_n);

endmodule

// ==== hdl/zx_master_conf.sv ====
`timescale 1ns/10ps

module zx_master_conf (
   input  logic       clk,
   input  logic       mrst_n,
   input  logic [7:0] addr,      // register bus address
   input  logic       iow,
   input  logic       ior,
   input  logic [7:0] din,
   output logic       boot_mode,
   output logic [zx_paging_pkg::PAGE_W-1:0] master_page,
   output logic [7:0] conf_rdata,
   output logic [1:0] timing_mode,
   output logic       disable_contention,
   output logic       issue2_keyboard_enabled,
   output logic       in_boot_mode
);

   logic       frozen;       // MASTERCONF bit 7
   logic [3:0] conf_hi;      // MASTERCONF bits 6..3
   logic       sel_conf;
   logic       sel_mapper;

   assign sel_conf   = (addr == zx_paging_pkg::MASTERCONF);
   assign sel_mapper = (addr == zx_paging_pkg::MASTERMAPPER);

   // --------------------------------------------------
   // configuration and mapper registers
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         boot_mode   <= 1'b1;  // power up into the boot ROM
         frozen      <= 1'b0;
         conf_hi     <= 4'h0;
         master_page <= '0;
      end else if (iow) begin
         if (sel_conf) begin
            conf_hi <= din[6:3];  // bits 2..1 belong to the dropped DivMMC
            if (!frozen) begin   // boot and freeze are one-shot
               boot_mode <= din[0];
               frozen    <= din[7];
            end
         end
         if (sel_mapper && boot_mode)
            master_page <= din[zx_paging_pkg::PAGE_W-1:0];
      end
   end

   // bit 6 timing high, 5 no contention, 4 timing low, 3 issue 2
   assign timing_mode             = {conf_hi[3], conf_hi[1]};
   assign disable_contention      = conf_hi[2];
   assign issue2_keyboard_enabled = conf_hi[0];
   assign in_boot_mode            = ~frozen;  // firmware still owns the machine

   // readback only during a register read cycle
   always_comb begin
      conf_rdata = 8'h00;
      if (ior && sel_conf)
         conf_rdata = {frozen, conf_hi, 2'b00, boot_mode};
      else if (ior && sel_mapper)
         conf_rdata = {1'b0, master_page};
   end

   // once frozen, a write of boot=1 must not bring the boot ROM back
   a_no_reboot : assert property (@(posedge clk) disable iff (!mrst_n)
      frozen |=> !$rose(boot_mode));

endmodule

// ==== hdl/zx_memory_map.sv ====
`timescale 1ns/10ps

module zx_memory_map #(
   parameter int ROM_BASE_PAGE = 8
) (
   input  logic        clk,
   input  logic        mrst_n,          // master reset
   input  logic        rst_n,           // CPU reset
   // CPU side
   input  logic [15:0] a,
   input  logic [7:0]  din,
   output logic [7:0]  dout,
   output logic        oe,
   input  logic        mreq_n,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   // register bus
   input  logic [7:0]  addr,
   input  logic        iow,
   input  logic        ior,
   // options and status
   input  logic        disable_1ffd,
   output logic        ioreqbank,
   output logic        in48kmode,
   output logic [1:0]  timing_mode,
   output logic        disable_contention,
   output logic        issue2_keyboard_enabled,
   output logic        in_boot_mode,
   output logic        access_to_screen,
   output logic        bootrom_cs,
   // SRAM
   output logic [zx_paging_pkg::SRAM_AW-1:0] sram_addr,
   output logic [7:0]  sram_wdata,
   input  logic [7:0]  sram_rdata,
   output logic        sram_we_n,
   output logic        sram_oe_n
);

   logic                              boot_mode;
   logic [zx_paging_pkg::PAGE_W-1:0]  master_page;
   logic [7:0]                        conf_rdata;
   logic [1:0]                        rom_bank;
   logic [2:0]                        ram_bank;
   logic                              allram_mode;
   zx_paging_pkg::allram_cfg_t        allram_cfg;
   logic                              mem_rd_q;

   zx_master_conf u_master_conf (
      .clk(clk), .mrst_n(mrst_n), .addr(addr), .iow(iow), .ior(ior), .din(din),
      .boot_mode(boot_mode), .master_page(master_page), .conf_rdata(conf_rdata),
      .timing_mode(timing_mode), .disable_contention(disable_contention),
      .issue2_keyboard_enabled(issue2_keyboard_enabled), .in_boot_mode(in_boot_mode)
   );

   zx_paging_regs u_paging_regs (
      .clk(clk), .mrst_n(mrst_n), .rst_n(rst_n), .a(a), .din(din),
      .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .disable_1ffd(disable_1ffd),
      .rom_bank(rom_bank), .ram_bank(ram_bank), .allram_mode(allram_mode),
      .allram_cfg(allram_cfg), .in48kmode(in48kmode), .ioreqbank(ioreqbank)
   );

   zx_addr_mapper #(.ROM_BASE_PAGE(ROM_BASE_PAGE)) u_addr_mapper (
      .clk(clk), .mrst_n(mrst_n), .a(a), .din(din), .mreq_n(mreq_n), .rd_n(rd_n),
      .wr_n(wr_n), .boot_mode(boot_mode), .master_page(master_page),
      .rom_bank(rom_bank), .ram_bank(ram_bank), .allram_mode(allram_mode),
      .allram_cfg(allram_cfg), .sram_addr(sram_addr), .sram_wdata(sram_wdata),
      .sram_we_n(sram_we_n), .sram_oe_n(sram_oe_n), .bootrom_cs(bootrom_cs),
      .access_to_screen(access_to_screen), .mem_rd_q(mem_rd_q)
   );

   zx_read_mux u_read_mux (
      .mem_rd_q(mem_rd_q), .sram_rdata(sram_rdata), .ior(ior), .addr(addr),
      .conf_rdata(conf_rdata), .dout(dout), .oe(oe)
   );

endmodule

// ==== hdl/zx_paging_pkg.sv ====
package zx_paging_pkg;

   // --------------------------------------------------
   // external memory geometry
   // --------------------------------------------------
   localparam int SRAM_AW  = 21;  // 2 MB of SRAM
   localparam int PAGE_W   = 7;   // 128 pages of 16K
   localparam int OFFSET_W = 14;  // byte within a 16K page

   // --------------------------------------------------
   // register bus addresses
   // --------------------------------------------------
   localparam logic [7:0] MASTERCONF   = 8'h00;  // boot, freeze, timing, keyboard
   localparam logic [7:0] MASTERMAPPER = 8'h01;  // page seen at C000 in boot mode

   // +3 all-RAM arrangement, taken from 1FFD bits 2..1
   // names list the pages seen at 0000/4000/8000/C000
   typedef enum logic [1:0] {
      CFG_0123 = 2'b00,
      CFG_4567 = 2'b01,
      CFG_4563 = 2'b10,
      CFG_4763 = 2'b11
   } allram_cfg_t;

   // 16K CPU slot, from address bits 15..14
   typedef enum logic [1:0] {
      SLOT_ROM  = 2'b00,  // 0000-3FFF
      SLOT_4000 = 2'b01,  // screen bank
      SLOT_8000 = 2'b10,
      SLOT_C000 = 2'b11   // paged bank
   } mem_slot_t;

endpackage

// ==== hdl/zx_paging_regs.sv ====
`timescale 1ns/10ps

module zx_paging_regs (
   input  logic        clk,
   input  logic        mrst_n,
   input  logic        rst_n,          // CPU reset also clears paging
   input  logic [15:0] a,
   input  logic [7:0]  din,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic        disable_1ffd,   // plain 128K decode
   output logic [1:0]  rom_bank,
   output logic [2:0]  ram_bank,
   output logic        allram_mode,
   output zx_paging_pkg::allram_cfg_t allram_cfg,
   output logic        in48kmode,
   output logic        ioreqbank
);

   logic [5:0] bank128;     // 7FFD bits 5..0, bit 3 unused here
   logic [2:0] bankplus3;   // 1FFD bits 2..0
   logic       locked;
   logic       io_wr;
   logic       sel_7ffd_p2a;
   logic       sel_7ffd_128;
   logic       sel_1ffd;

   // --------------------------------------------------
   // port decode
   // --------------------------------------------------
   assign sel_7ffd_p2a = !a[1] && (a[15:14] == 2'b01);
   assign sel_1ffd     = !a[1] && (a[15:12] == 4'b0001);
   assign sel_7ffd_128 = !a[1] && !a[15];      // loose 128K decode
   assign io_wr        = !iorq_n && !wr_n;
   assign locked       = bank128[5];

   // flag for the 128K decode, any I/O direction
   assign ioreqbank = disable_1ffd && !iorq_n && (!wr_n || !rd_n) && sel_7ffd_128;

   always_ff @(posedge clk) begin
      if (!mrst_n || !rst_n) begin
         bank128   <= 6'h00;
         bankplus3 <= 3'h0;
      end else if (io_wr && !locked) begin
         if (!disable_1ffd) begin            // +2A/+3 decode
            if (sel_1ffd)
               bankplus3 <= din[2:0];
            else if (sel_7ffd_p2a)
               bank128 <= din[5:0];
         end else if (sel_7ffd_128) begin
            bank128 <= din[5:0];             // 1FFD is invisible here
         end
      end
   end

   // --------------------------------------------------
   // decoded paging state
   // --------------------------------------------------
   assign ram_bank    = bank128[2:0];
   assign rom_bank    = {bankplus3[2], bank128[4]};  // 4 ROMs on +3
   assign allram_mode = bankplus3[0];
   assign allram_cfg  = zx_paging_pkg::allram_cfg_t'(bankplus3[2:1]);
   assign in48kmode   = locked;

   // lock holds until the next reset, whatever the CPU writes
   a_lock_holds : assert property (@(posedge clk) disable iff (!mrst_n || !rst_n)
      locked |=> $stable({bank128, bankplus3}));

endmodule

// ==== hdl/zx_read_mux.sv ====
`timescale 1ns/10ps

module zx_read_mux (
   input  logic       mem_rd_q,     // SRAM read issued last cycle
   input  logic [7:0] sram_rdata,
   input  logic       ior,
   input  logic [7:0] addr,         // register bus address
   input  logic [7:0] conf_rdata,
   output logic [7:0] dout,
   output logic       oe
);

   logic reg_hit;

   assign reg_hit = ior && (addr == zx_paging_pkg::MASTERCONF ||
                            addr == zx_paging_pkg::MASTERMAPPER);

   // --------------------------------------------------
   // CPU read data, memory first
   // --------------------------------------------------
   always_comb begin
      if (mem_rd_q) begin
         dout = sram_rdata;
         oe   = 1'b1;
      end else if (reg_hit) begin
         dout = conf_rdata;         // paging unit registers
         oe   = 1'b1;
      end else begin
         dout = 8'hFF;              // idle bus
         oe   = 1'b0;
      end
   end

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
   parameter int PERIOD     = 40,  // ns
   parameter int RST_CYCLES = 5
) (
   output logic clk,
   output logic mrst_n
);

   initial clk = 1'b0;
   always #(PERIOD / 2) clk = ~clk;

   // master reset held for a few edges, released on a falling edge
   initial begin
      mrst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      mrst_n = 1'b1;
   end

endmodule

// ==== tb/tb_zx_memory_map.sv ====
`timescale 1ns/10ps

module tb_zx_memory_map;

   localparam int ROM_BASE_PAGE   = 16;  // not the default, so the override must reach the mapper
   localparam logic [7:0] CONF_ADDR = zx_paging_pkg::MASTERCONF;
   localparam logic [7:0] MAP_ADDR  = zx_paging_pkg::MASTERMAPPER;
   // all-RAM pages, indexed by arrangement then slot
   localparam logic [6:0] ALLRAM_PAGES [4][4] = '{'{7'd0, 7'd1, 7'd2, 7'd3},
                                                  '{7'd4, 7'd5, 7'd6, 7'd7},
                                                  '{7'd4, 7'd5, 7'd6, 7'd3},
                                                  '{7'd4, 7'd7, 7'd6, 7'd3}};

   logic        clk;
   logic        mrst_n;
   logic        rst_n;
   logic [15:0] a;
   logic [7:0]  din;
   logic [7:0]  dout;
   logic        oe;
   logic        mreq_n;
   logic        iorq_n;
   logic        rd_n;
   logic        wr_n;
   logic [7:0]  addr;
   logic        iow;
   logic        ior;
   logic        disable_1ffd;
   logic        ioreqbank;
   logic        in48kmode;
   logic [1:0]  timing_mode;
   logic        disable_contention;
   logic        issue2_keyboard_enabled;
   logic        in_boot_mode;
   logic        access_to_screen;
   logic        bootrom_cs;
   logic [20:0] sram_addr;
   logic [7:0]  sram_wdata;
   logic [7:0]  sram_rdata;
   logic        sram_we_n;
   logic        sram_oe_n;

   // register model, built from the writes driven below
   logic        m_boot;
   logic        m_frozen;
   logic [6:3]  m_cbits;     // MASTERCONF bits 6..3
   logic [6:0]  m_mpage;
   logic [5:0]  m_b128;      // 7FFD bits 5..0
   logic [2:0]  m_p3;        // 1FFD bits 2..0
   // expected pipeline outputs for the request sampled last edge
   logic [20:0] exp_addr;
   logic        exp_addr_chk;
   logic [7:0]  exp_wdata;
   logic        exp_we_n;
   logic        exp_oe_n;
   logic        exp_cs;
   logic        exp_scr;
   logic [7:0]  exp_rb;
   logic        exp_ioreq;
   logic [4:0]  exp_levels;
   logic [15:0] lfsr_state = 16'd33;
   int          value_errs = 0;
   int          timeouts   = 0;

   tb_clock_gen #(.PERIOD(40), .RST_CYCLES(5)) u_clk_gen (.clk(clk), .mrst_n(mrst_n));

   zx_memory_map #(.ROM_BASE_PAGE(ROM_BASE_PAGE)) DUT (.*);

   // --------------------------------------------------
   // reference model
   // --------------------------------------------------
   function automatic logic [6:0] ref_page(input logic [1:0] slot);
      logic [6:0] pg;
      if (m_boot)
         pg = (slot == 2'd1) ? 7'd5 : (slot == 2'd2) ? 7'd2 : m_mpage;
      else if (m_p3[0])
         pg = ALLRAM_PAGES[m_p3[2:1]][slot];  // +3 special paging
      else begin
         case (slot)
            2'd0:    pg = 7'(ROM_BASE_PAGE) + {5'd0, m_p3[2], m_b128[4]};
            2'd1:    pg = 7'd5;
            2'd2:    pg = 7'd2;
            default: pg = {4'd0, m_b128[2:0]};
         endcase
      end
      return pg;
   endfunction

   always @(posedge clk) begin : ref_model
      logic [1:0] slot;
      logic       rom_slot;
      logic       io_wr;
      slot     = a[15:14];
      rom_slot = (slot == 2'd0);
      io_wr    = !iorq_n && !wr_n && !m_b128[5];  // lock blocks both ports
      exp_addr     <= {ref_page(slot), a[13:0]};
      exp_addr_chk <= !mreq_n && !(m_boot && rom_slot);  // boot ROM leaves SRAM alone
      exp_wdata    <= din;
      if (!mrst_n) begin
         exp_we_n <= 1'b1;
         exp_oe_n <= 1'b1;
         exp_cs   <= 1'b0;
         exp_scr  <= 1'b0;
      end else begin
         exp_we_n <= mreq_n || wr_n || (rom_slot && (m_boot || !m_p3[0]));
         exp_oe_n <= mreq_n || rd_n || (rom_slot && m_boot);
         exp_cs   <= !mreq_n && rom_slot && m_boot;
         exp_scr  <= !mreq_n && !m_boot && !m_p3[0] &&
                     (slot == 2'd1 || (slot == 2'd3 && m_b128[0]));
      end
      if (!mrst_n) begin
         m_boot   <= 1'b1;
         m_frozen <= 1'b0;
         m_cbits  <= '0;
         m_mpage  <= '0;
      end else if (iow) begin
         if (addr == CONF_ADDR) begin
            m_cbits <= din[6:3];
            if (!m_frozen) begin
               m_boot   <= din[0];
               m_frozen <= din[7];
            end
         end else if (addr == MAP_ADDR && m_boot)
            m_mpage <= din[6:0];
      end
      if (!mrst_n || !rst_n) begin
         m_b128 <= '0;
         m_p3   <= '0;
      end else if (io_wr) begin
         if (disable_1ffd) begin
            if (!a[15] && !a[1]) m_b128 <= din[5:0];  // 128K decode
         end else if (!a[1] && a[15:14] == 2'b01)
            m_b128 <= din[5:0];
         else if (!a[1] && a[15:12] == 4'b0001)
            m_p3 <= din[2:0];
      end
   end

   assign exp_rb     = (addr == CONF_ADDR) ? {m_frozen, m_cbits, 2'b00, m_boot} : {1'b0, m_mpage};
   assign exp_ioreq  = disable_1ffd && !iorq_n && (!wr_n || !rd_n) && !a[15] && !a[1];
   assign exp_levels = {m_cbits[6], m_cbits[4], m_cbits[5], m_cbits[3], !m_frozen};

   task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
      value_errs++;
      $display("Error %0t %s got %0h expected %0h", $time, name, got, exp);
   endtask

   // --------------------------------------------------
   // checks
   // --------------------------------------------------
   a_addr : assert property (@(posedge clk) disable iff (!mrst_n)
      exp_addr_chk |-> sram_addr == exp_addr)
      else value_error("sram_addr", $sampled(sram_addr), $sampled(exp_addr));
   a_wdata : assert property (@(posedge clk) disable iff (!mrst_n)
      !exp_we_n |-> sram_wdata == exp_wdata)
      else value_error("sram_wdata", $sampled(sram_wdata), $sampled(exp_wdata));
   a_we : assert property (@(posedge clk) disable iff (!mrst_n) sram_we_n == exp_we_n)
      else value_error("sram_we_n", $sampled(sram_we_n), $sampled(exp_we_n));
   a_oe : assert property (@(posedge clk) disable iff (!mrst_n) sram_oe_n == exp_oe_n)
      else value_error("sram_oe_n", $sampled(sram_oe_n), $sampled(exp_oe_n));
   a_cs : assert property (@(posedge clk) disable iff (!mrst_n) bootrom_cs == exp_cs)
      else value_error("bootrom_cs", $sampled(bootrom_cs), $sampled(exp_cs));
   a_scr : assert property (@(posedge clk) disable iff (!mrst_n) access_to_screen == exp_scr)
      else value_error("access_to_screen", $sampled(access_to_screen), $sampled(exp_scr));
   a_ioreq : assert property (@(posedge clk) disable iff (!mrst_n) ioreqbank == exp_ioreq)
      else value_error("ioreqbank", $sampled(ioreqbank), $sampled(exp_ioreq));
   a_lock : assert property (@(posedge clk) disable iff (!mrst_n) in48kmode == m_b128[5])
      else value_error("in48kmode", $sampled(in48kmode), $sampled(m_b128[5]));
   a_levels : assert property (@(posedge clk) disable iff (!mrst_n)
      {timing_mode, disable_contention, issue2_keyboard_enabled, in_boot_mode} == exp_levels)
      else value_error("config levels", $sampled({timing_mode, disable_contention,
                       issue2_keyboard_enabled, in_boot_mode}), $sampled(exp_levels));
   a_readback : assert property (@(posedge clk) disable iff (!mrst_n)
      (ior && addr <= MAP_ADDR && sram_oe_n) |-> (oe && dout == exp_rb))
      else value_error("dout", $sampled(dout), $sampled(exp_rb));
   a_rd_data : assert property (@(posedge clk) disable iff (!mrst_n)
      !sram_oe_n |-> (oe && dout == sram_rdata))
      else value_error("dout", $sampled(dout), $sampled(sram_rdata));
   a_idle : assert property (@(posedge clk) disable iff (!mrst_n)
      (sram_oe_n && !(ior && addr <= MAP_ADDR)) |-> (!oe && dout == 8'hFF))
      else value_error("oe, dout", $sampled({oe, dout}), 9'h0FF);

   // --------------------------------------------------
   // stimulus helpers, all driven on the falling edge
   // --------------------------------------------------
   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         bits       = {bits[14:0], lfsr_state[0]};
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
      end
      return bits;
   endfunction

   task automatic set_idle;
      mreq_n = 1'b1;
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      wr_n   = 1'b1;
      iow    = 1'b0;
      ior    = 1'b0;
   endtask

   task automatic mem_cycle(input logic [1:0] slot, input logic write);
      logic [15:0] r;
      r = rand_bits(14);
      set_idle();
      a          = {slot, r[13:0]};
      r          = rand_bits(8);
      din        = r[7:0];
      r          = rand_bits(8);
      sram_rdata = r[7:0];
      mreq_n     = 1'b0;
      ior        = !write;   // register read competes with the SRAM data
      if (write) wr_n = 1'b0;
      else rd_n = 1'b0;
      @(negedge clk);
   endtask

   task automatic io_cycle(input logic [15:0] port, input logic write, input logic [7:0] data);
      set_idle();
      a      = port;
      din    = data;
      iorq_n = 1'b0;
      if (write) wr_n = 1'b0;
      else rd_n = 1'b0;
      @(negedge clk);
   endtask

   task automatic reg_cycle(input logic [7:0] ra, input logic write, input logic [7:0] data);
      set_idle();
      addr = ra;
      din  = data;
      iow  = write;
      ior  = !write;
      @(negedge clk);
   endtask

   // every slot read, then a ROM-slot write and a RAM write
   task automatic sweep_slots;
      for (int s = 0; s < 4; s++) mem_cycle(2'(s), 1'b0);
      mem_cycle(2'd0, 1'b1);
      mem_cycle(2'd2, 1'b1);
   endtask

   task automatic cpu_reset;
      set_idle();
      rst_n = 1'b0;
      @(negedge clk);
      rst_n = 1'b1;
   endtask

   task automatic wait_reset_release(output logic ok);
      int cnt;
      cnt = 0;
      while (!mrst_n && cnt < 50) begin
         @(negedge clk);
         cnt++;
      end
      ok = mrst_n;
      if (!ok) begin
         timeouts++;
         $display("timed out waiting for the master reset to be released");
      end
   endtask

   task automatic finish_run;
      $display("value errors %0d, timeouts %0d", value_errs, timeouts);
      if (value_errs == 0 && timeouts == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   endtask

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------
   initial begin : stimulus
      logic        ok;
      logic [15:0] r;
      a            = '0;
      din          = '0;
      addr         = '0;
      rst_n        = 1'b1;
      disable_1ffd = 1'b0;
      sram_rdata   = '0;
      set_idle();
      wait_reset_release(ok);
      if (ok) begin
         for (int i = 0; i < 3; i++) begin   // boot mode, mapper page at C000
            r = rand_bits(7);
            reg_cycle(MAP_ADDR, 1'b1, r[7:0]);
            reg_cycle(MAP_ADDR, 1'b0, 8'h00);
            sweep_slots();
         end
         reg_cycle(CONF_ADDR, 1'b1, 8'hC8);  // freeze and leave boot
         reg_cycle(CONF_ADDR, 1'b0, 8'h00);
         reg_cycle(CONF_ADDR, 1'b1, 8'h01);  // boot again, must be ignored
         reg_cycle(CONF_ADDR, 1'b0, 8'h00);
         reg_cycle(MAP_ADDR, 1'b1, 8'h55);   // mapper locked out too
         reg_cycle(MAP_ADDR, 1'b0, 8'h00);
         for (int i = 0; i < 12; i++) begin  // normal 128K paging, every bank then random
            r = rand_bits(5);
            io_cycle(16'h1FFD, 1'b1, {5'd0, r[4], 2'b00});
            io_cycle(16'h7FFD, 1'b1, {3'd0, r[3], 1'b0, (i < 8) ? 3'(i) : r[2:0]});
            sweep_slots();
         end
         for (int c = 0; c < 4; c++) begin   // +3 all-RAM layouts
            io_cycle(16'h1FFD, 1'b1, {5'd0, 2'(c), 1'b1});
            sweep_slots();
         end
         io_cycle(16'h1FFD, 1'b1, 8'h00);
         io_cycle(16'h7FFD, 1'b1, 8'h23);    // lock with bank 3
         io_cycle(16'h7FFD, 1'b1, 8'h04);
         io_cycle(16'h1FFD, 1'b1, 8'h01);
         sweep_slots();
         cpu_reset();
         io_cycle(16'h7FFD, 1'b1, 8'h06);
         sweep_slots();
         disable_1ffd = 1'b1;                // loose 128K decode
         io_cycle(16'h3F7D, 1'b1, 8'h17);
         sweep_slots();
         io_cycle(16'h1FFD, 1'b1, 8'h05);    // lands in 7FFD, never 1FFD
         io_cycle(16'hBFFD, 1'b1, 8'h01);    // bit 15 high, not decoded
         io_cycle(16'h7FFD, 1'b0, 8'h00);
         sweep_slots();
         set_idle();
         repeat (3) @(negedge clk);          // drain the pipeline
      end
      finish_run();
   end

endmodule

// ==== zx_memory_map.f ====
hdl/zx_paging_pkg.sv
hdl/zx_master_conf.sv
hdl/zx_paging_regs.sv
hdl/zx_addr_mapper.sv
hdl/zx_read_mux.sv
hdl/zx_memory_map.sv
tb/tb_clock_gen.sv
tb/tb_zx_memory_map.sv
